// File: vlog.f
+incdir+include
design/branch_pkg.sv
design/cpu_types_pkg.sv
design/exec_stream_if.sv
design/decode_stage.sv
design/branch_early_resolve.sv
design/delayed_exec.sv
design/result_stage.sv
design/delayed_exec_unit.sv
test/tb_delayed_exec_unit.sv

// File: Makefile
SRCS := include/cpu_defs.svh $(wildcard design/*.sv) test/tb_delayed_exec_unit.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_delayed_exec_unit: vlog.f $(SRCS)
	verilator --binary --top-module tb_delayed_exec_unit -f vlog.f

run: obj_dir/Vtb_delayed_exec_unit
	-./obj_dir/Vtb_delayed_exec_unit > sim.log 2>&1
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_delayed_exec_unit.sv
module tb_delayed_exec_unit;

import cpu_types_pkg::*;
import branch_pkg::*;

localparam int IN_DEPTH       = 2;
localparam int RESULT_DEPTH   = 2;
localparam int OUT_CREDITS    = 2;
localparam int N_RANDOM       = 400;
localparam int TIMEOUT_CYCLES = N_RANDOM * 20;

typedef struct {
	uint32_t  result;
	logic     bvalid;
	addr_t    pc;
	logic [1:0] cf;
	counter_t counter;
	logic     taken;
	addr_t    target;
	logic     mispredict;
} expect_t;

logic             clk, rst_n, in_valid, in_credit, out_valid, out_credit;
addr_t            in_pc;
instr_t           in_instr;
uint32_t [1:0]    in_reg;
branch_predict_t  in_predict;
uint32_t          out_result;
branch_resolved_t out_branch;

integer  seed;
int      in_cred, consumer_held, cycles, accepted, credit_pulses, hold_seen, lat;
logic    hold_credits, checks_on;
expect_t exp_q[$];
expect_t head_exp;

delayed_exec_unit #(
	.IN_DEPTH     (IN_DEPTH),
	.RESULT_DEPTH (RESULT_DEPTH),
	.OUT_CREDITS  (OUT_CREDITS)
) dut0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_pc      (in_pc),
	.in_instr   (in_instr),
	.in_reg     (in_reg),
	.in_predict (in_predict),
	.in_credit  (in_credit),
	.out_valid  (out_valid),
	.out_result (out_result),
	.out_branch (out_branch),
	.out_credit (out_credit)
);

always #20 clk = ~clk;

task automatic report_failure(input string msg);
	$display("CHECK FAILED at time %0t: %s", $time, msg);
	$display("CHECKS FAILED");
	$fatal(1, "stopped at first failing check");
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// ops numbered alu 0 to 13 then branches 14 to 21 then jal and jalr
function automatic logic [5:0] funct_of(input int k);
	case (k)
		0:       return 6'h24;
		1:       return 6'h25;
		2:       return 6'h26;
		3:       return 6'h27;
		4:       return 6'h21;
		5:       return 6'h23;
		6:       return 6'h00;
		7:       return 6'h04;
		8:       return 6'h02;
		9:       return 6'h06;
		10:      return 6'h03;
		11:      return 6'h07;
		12:      return 6'h2a;
		13:      return 6'h2b;
		default: return 6'h09;
	endcase
endfunction

function automatic expect_t compute_expect(input int k, input addr_t pc, input instr_t ins,
	input uint32_t r0, input uint32_t r1_raw, input branch_predict_t p);
	expect_t e;
	uint32_t r1;
	shamt_t  sa, sv;
	addr_t   pc4;
	r1  = (k >= 16 && k <= 21) ? 32'd0 : r1_raw;
	sa  = ins[10:6];
	sv  = r0[4:0];
	pc4 = pc + 32'd4;
	case (k)
		0:  e.result = r0 & r1;
		1:  e.result = r0 | r1;
		2:  e.result = r0 ^ r1;
		3:  e.result = ~(r0 | r1);
		4:  e.result = r0 + r1;
		5:  e.result = r0 - r1;
		6:  e.result = r1 << sa;
		7:  e.result = r1 << sv;
		8:  e.result = r1 >> sa;
		9:  e.result = r1 >> sv;
		10: e.result = $signed(r1) >>> sa;
		11: e.result = $signed(r1) >>> sv;
		12: e.result = {31'b0, ($signed(r0) < $signed(r1))};
		13: e.result = {31'b0, (r0 < r1)};
		20, 21, 22, 23: e.result = pc + 32'd8;
		default: e.result = 32'd0;
	endcase
	case (k)
		14:      e.taken = (r0 == r1);
		15:      e.taken = (r0 != r1);
		16:      e.taken = ($signed(r0) <= 0);
		17:      e.taken = ($signed(r0) > 0);
		18, 20:  e.taken = ($signed(r0) < 0);
		19, 21:  e.taken = ($signed(r0) >= 0);
		default: e.taken = 1'b1;
	endcase
	case (k)
		22:      e.target = {pc4[31:28], ins[25:0], 2'b00};
		23:      e.target = r0;
		default: e.target = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
	endcase
	if (k >= 22)
		e.mispredict = !p.valid || (p.target != e.target);
	else
		e.mispredict = (p.valid && (p.taken != e.taken))
			|| (e.taken && (!p.valid || (p.target != e.target)));
	if (k >= 14 && k <= 19)
		e.cf = 2'd1;
	else if (k >= 20 && k <= 22)
		e.cf = 2'd2;
	else if (k == 23)
		e.cf = 2'd3;
	else
		e.cf = 2'd0;
	e.bvalid  = (k >= 14);
	e.pc      = pc;
	e.counter = p.counter;
	return e;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic drive_one(input bit fixed, input int fixed_k);
	int              k;
	instr_t          ins;
	uint32_t         r0, r1;
	addr_t           pc;
	branch_predict_t p;
	expect_t         e;
	while (in_cred == 0)
		@(negedge clk);
	k   = fixed ? fixed_k : int'($unsigned($random(seed)) % 24);
	ins = $random(seed);
	if (k <= 13 || k == 23) begin
		ins[31:26] = 6'h00;
		ins[5:0]   = funct_of(k);
	end else if (k >= 18 && k <= 21) begin
		ins[31:26] = 6'h01;
		ins[20:16] = (k == 18) ? 5'h00 : (k == 19) ? 5'h01 : (k == 20) ? 5'h10 : 5'h11;
	end else if (k == 22) begin
		ins[31:26] = 6'h03;
	end else begin
		ins[31:26] = 6'(k - 10);
	end
	r0 = $random(seed);
	r1 = $random(seed);
	case ($unsigned($random(seed)) % 4)
		0:       r1 = r0;
		1:       r0 = 32'd0;
		default: ;
	endcase
	pc        = $random(seed);
	pc[1:0]   = 2'b00;
	p.valid   = 1'($random(seed));
	p.taken   = 1'($random(seed));
	p.target  = $random(seed);
	p.counter = 2'($random(seed));
	e = compute_expect(k, pc, ins, r0, r1, p);
	// correct prediction for about a third
	if ($unsigned($random(seed)) % 3 == 0) begin
		p.valid  = 1'b1;
		p.taken  = e.taken;
		p.target = e.target;
		e = compute_expect(k, pc, ins, r0, r1, p);
	end
	in_pc      = pc;
	in_instr   = ins;
	in_reg[0]  = r0;
	in_reg[1]  = r1;
	in_predict = p;
	exp_q.push_back(e);
	in_valid = 1'b1;
	@(negedge clk);
	in_valid = 1'b0;
endtask

// consumer returns entries at random
always @(negedge clk) begin
	if (!rst_n)
		out_credit = 1'b0;
	else
		out_credit = (consumer_held > 0) && !hold_credits && (($random(seed) & 1) != 0);
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= TIMEOUT_CYCLES) begin
		$display("run timed out after %0d cycles", cycles);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always @(posedge clk) begin
	if (!rst_n) begin
		in_cred       = IN_DEPTH;
		consumer_held = 0;
		accepted      = 0;
		credit_pulses = 0;
	end else begin
		if (in_valid) begin
			in_cred--;
			accepted++;
		end
		if (in_credit) begin
			in_cred++;
			credit_pulses++;
		end
		if (out_credit)
			consumer_held--;
		if (out_valid) begin
			assert (exp_q.size() != 0)
				else report_failure("result appeared with no instruction outstanding");
			head_exp = exp_q.pop_front();
			consumer_held++;
			if (hold_credits)
				hold_seen++;
			assert (out_result == head_exp.result)
				else report_failure($sformatf("result %h, expected %h",
					out_result, head_exp.result));
			assert (out_branch.valid == head_exp.bvalid)
				else report_failure($sformatf("branch valid %b, expected %b",
					out_branch.valid, head_exp.bvalid));
			if (head_exp.bvalid) begin
				assert (out_branch.pc == head_exp.pc && out_branch.cf == head_exp.cf
					&& out_branch.counter == head_exp.counter)
					else report_failure($sformatf("branch pc %h cf %0d, expected %h cf %0d",
						out_branch.pc, out_branch.cf, head_exp.pc, head_exp.cf));
				assert (out_branch.taken == head_exp.taken
					&& out_branch.target == head_exp.target)
					else report_failure($sformatf("taken %b target %h, expected %b %h",
						out_branch.taken, out_branch.target, head_exp.taken,
						head_exp.target));
				assert (out_branch.mispredict == head_exp.mispredict)
					else report_failure($sformatf("mispredict %b, expected %b",
						out_branch.mispredict, head_exp.mispredict));
			end
		end
	end
end

assert property (@(posedge clk) disable iff (!checks_on) !rst_n |-> !out_valid && !in_credit)
	else report_failure("out_valid or in_credit high during reset");

assert property (@(posedge clk) disable iff (!checks_on) !rst_n |=> !out_valid && !in_credit)
	else report_failure("out_valid or in_credit high right after reset");

assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> consumer_held < OUT_CREDITS)
	else report_failure("out_valid while the consumer had no free credit");

initial begin
	seed          = 77646;
	clk           = 1'b0;
	rst_n         = 1'b0;
	in_valid      = 1'b0;
	in_pc         = '0;
	in_instr      = '0;
	in_reg        = '0;
	in_predict    = '0;
	out_credit    = 1'b0;
	hold_credits  = 1'b0;
	checks_on     = 1'b0;
	cycles        = 0;
	hold_seen     = 0;
	in_cred       = IN_DEPTH;
	consumer_held = 0;
	@(posedge clk);
	@(negedge clk);
	checks_on = 1'b1;
	repeat (15) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;

	// latency through an empty pipe
	@(negedge clk);
	drive_one(1'b1, 4);
	lat = 0;
	do begin
		@(posedge clk);
		lat++;
		@(negedge clk);
	end while (!out_valid);
	assert (lat == 3)
		else report_failure($sformatf("latency %0d cycles, expected 3", lat));
	while (exp_q.size() != 0 || consumer_held != 0)
		@(negedge clk);

	// consumer withholds credits
	hold_credits = 1'b1;
	hold_seen    = 0;
	repeat (6) drive_one(1'b0, 0);
	repeat (20) @(negedge clk);
	assert (hold_seen <= OUT_CREDITS)
		else report_failure($sformatf("%0d results with credits withheld", hold_seen));
	hold_credits = 1'b0;

	repeat (N_RANDOM) begin
		if (($random(seed) & 3) == 0)
			@(negedge clk);
		drive_one(1'b0, 0);
	end
	while (exp_q.size() != 0)
		@(negedge clk);
	repeat (10) @(negedge clk);
	assert (credit_pulses == accepted)
		else report_failure($sformatf("accepted %0d, credit pulses %0d",
			accepted, credit_pulses));
	$display("ALL CHECKS PASSED");
	$finish;
end

endmodule

// File: design/delayed_exec_unit.sv
module delayed_exec_unit #(
	parameter int IN_DEPTH     = 2,
	parameter int RESULT_DEPTH = 2,
	parameter int OUT_CREDITS  = 2
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  cpu_types_pkg::addr_t         in_pc,
	input  cpu_types_pkg::instr_t        in_instr,
	input  cpu_types_pkg::uint32_t [1:0] in_reg,
	input  branch_pkg::branch_predict_t  in_predict,
	output logic                         in_credit,
	output logic                         out_valid,
	output cpu_types_pkg::uint32_t       out_result,
	output branch_pkg::branch_resolved_t out_branch,
	input  logic                         out_credit
);

import cpu_types_pkg::*;
import branch_pkg::*;

logic             rec_valid, rec_credit, stall;
pipeline_exec_t   rec, exec_result;
branch_resolved_t exec_branch;

exec_stream_if stream ();

decode_stage #(
	.IN_DEPTH (IN_DEPTH)
) decode0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_pc      (in_pc),
	.in_instr   (in_instr),
	.in_reg     (in_reg),
	.in_predict (in_predict),
	.in_credit  (in_credit),
	.rec_valid  (rec_valid),
	.rec        (rec),
	.rec_credit (rec_credit)
);

branch_early_resolve #(
	.RESULT_DEPTH (RESULT_DEPTH)
) early0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.rec_valid  (rec_valid),
	.rec        (rec),
	.rec_credit (rec_credit),
	.down       (stream.src)
);

delayed_exec exec0 (
	.stall           (stall),
	.data            (stream.data),
	.result          (exec_result),
	.early_resolved  (stream.early),
	.resolved_branch (exec_branch)
);

result_stage #(
	.RESULT_DEPTH (RESULT_DEPTH),
	.OUT_CREDITS  (OUT_CREDITS)
) result0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.up          (stream.dst),
	.exec_result (exec_result),
	.exec_branch (exec_branch),
	.stall       (stall),
	.out_valid   (out_valid),
	.out_result  (out_result),
	.out_branch  (out_branch),
	.out_credit  (out_credit)
);

endmodule

// File: design/result_stage.sv
module result_stage #(
	parameter int RESULT_DEPTH = 2,
	parameter int OUT_CREDITS  = 2
) (
	input  logic                          clk,
	input  logic                          rst_n,
	exec_stream_if.dst                    up,
	input  cpu_types_pkg::pipeline_exec_t exec_result,
	input  branch_pkg::branch_resolved_t  exec_branch,
	output logic                          stall,
	output logic                          out_valid,
	output cpu_types_pkg::uint32_t        out_result,
	output branch_pkg::branch_resolved_t  out_branch,
	input  logic                          out_credit
);

import cpu_types_pkg::*;
import branch_pkg::*;

localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
localparam int CNT_W = $clog2(RESULT_DEPTH + 1);
localparam int CRD_W = $clog2(OUT_CREDITS + 1);

typedef struct packed {
	uint32_t          result;
	branch_resolved_t branch;
} res_entry_t;

res_entry_t       res_mem [RESULT_DEPTH];
logic [PTR_W-1:0] wr_ptr, rd_ptr;
logic [CNT_W-1:0] count;
logic [CRD_W-1:0] out_cnt;
logic             push, pop, full;
res_entry_t       head;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	return (p == PTR_W'(RESULT_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

// the early stage only drives valid while it holds a credit
assign stall = !up.valid;
assign push  = !stall;
assign full  = (count == CNT_W'(RESULT_DEPTH));
assign pop   = (count != '0) && (out_cnt != '0);

assign up.credit  = pop;
assign out_valid  = pop;
assign head       = res_mem[rd_ptr];
assign out_result = head.result;
assign out_branch = head.branch;

always_ff @(posedge clk) begin
	if (push)
		res_mem[wr_ptr] <= '{result: exec_result.result, branch: exec_branch};
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr  <= '0;
		rd_ptr  <= '0;
		count   <= '0;
		out_cnt <= CRD_W'(OUT_CREDITS);
	end else begin
		if (push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (pop)
			rd_ptr <= ptr_inc(rd_ptr);
		count   <= count + CNT_W'(push) - CNT_W'(pop);
		out_cnt <= out_cnt - CRD_W'(pop) + CRD_W'(out_credit);
	end
end

assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
	else $error("push into full result FIFO");

// consumer returned more credits than it owns
assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= CRD_W'(OUT_CREDITS))
	else $error("out credit counter above consumer depth");

endmodule

// File: design/delayed_exec.sv
`include "cpu_defs.svh"

module delayed_exec (
	input  logic                               stall,
	input  cpu_types_pkg::pipeline_exec_t      data,
	output cpu_types_pkg::pipeline_exec_t      result,
	input  branch_pkg::branch_early_resolved_t early_resolved,
	output branch_pkg::branch_resolved_t       resolved_branch
);

import cpu_types_pkg::*;
import branch_pkg::*;

oper_t           op;
uint32_t         reg1, reg2, alu_out, sub_u;
shamt_t          shamt, shamt_var;
logic            signed_lt, unsigned_lt;
logic            taken, mispredict, target_miss;
branch_predict_t pred;

assign op        = data.decoded.op;
assign reg1      = data.delayed_reg[0];
assign reg2      = data.delayed_reg[1];
assign shamt     = data.instr[`INSTR_SHAMT];
assign shamt_var = reg1[4:0];
assign pred      = data.branch_predict;

assign sub_u       = reg1 - reg2;
// with differing signs the negative one is smaller
assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = (reg1 < reg2);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	case (op)
		OP_AND:  alu_out = reg1 & reg2;
		OP_OR:   alu_out = reg1 | reg2;
		OP_XOR:  alu_out = reg1 ^ reg2;
		OP_NOR:  alu_out = ~(reg1 | reg2);
		OP_ADDU: alu_out = reg1 + reg2;
		OP_SUBU: alu_out = sub_u;
		OP_SLL:  alu_out = reg2 << shamt;
		OP_SLLV: alu_out = reg2 << shamt_var;
		OP_SRL:  alu_out = reg2 >> shamt;
		OP_SRLV: alu_out = reg2 >> shamt_var;
		OP_SRA:  alu_out = $signed(reg2) >>> shamt;
		OP_SRAV: alu_out = $signed(reg2) >>> shamt_var;
		OP_SLT:  alu_out = {31'b0, signed_lt};
		OP_SLTU: alu_out = {31'b0, unsigned_lt};
		// link value preset by decode
		default: alu_out = data.result;
	endcase
end

always_comb begin
	result        = data;
	result.result = alu_out;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign target_miss = !pred.valid || (pred.target != early_resolved.target);

always_comb begin
	case (op)
		OP_JAL, OP_JALR: taken = 1'b1;
		default: taken = early_resolved.negate
			^ ((early_resolved.mask_sign & early_resolved.cond_sign)
			| (early_resolved.mask_equal & early_resolved.cond_equal));
	endcase

	case (op)
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL: begin
			mispredict = pred.valid && (pred.taken != taken);
			if (taken)
				mispredict = mispredict || target_miss;
		end
		OP_JAL, OP_JALR: mispredict = target_miss;
		default:         mispredict = 1'b1;
	endcase
end

assign resolved_branch.valid = data.valid && data.decoded.is_controlflow
	&& data.decoded.delayed_exec && !stall;
assign resolved_branch.pc         = data.pc;
assign resolved_branch.cf         = data.decoded.cf;
assign resolved_branch.counter    = pred.counter;
assign resolved_branch.taken      = taken;
assign resolved_branch.target     = early_resolved.target;
assign resolved_branch.mispredict = mispredict;

// unknown encodings must never leave the early stage
always_comb begin
	if (!stall)
		assert (op != OP_INVALID)
			else $error("invalid op reached delayed execution");
end

endmodule

// File: design/branch_early_resolve.sv
`include "cpu_defs.svh"

module branch_early_resolve #(
	parameter int RESULT_DEPTH = 2
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          rec_valid,
	input  cpu_types_pkg::pipeline_exec_t rec,
	output logic                          rec_credit,
	exec_stream_if.src                    down
);

import cpu_types_pkg::*;
import branch_pkg::*;

localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

pipeline_exec_t         ent;
branch_early_resolved_t ent_early, early_next;
logic                   ent_valid;
logic [CNT_W-1:0]       res_cnt;
logic                   send;
addr_t                  pc_plus4;
logic [15:0]            imm16;
uint32_t                br_offset;

assign send       = ent_valid && (res_cnt != '0);
assign rec_credit = send;
assign down.valid = send;
assign down.data  = ent;
assign down.early = ent_early;

assign pc_plus4  = rec.pc + 32'd4;
assign imm16     = rec.instr[`INSTR_IMM16];
assign br_offset = {{14{imm16[15]}}, imm16, 2'b00};

always_comb begin
	early_next.cond_equal = (rec.delayed_reg[0] == rec.delayed_reg[1]);
	early_next.cond_sign  = rec.delayed_reg[0][31];
	early_next.negate     = 1'b0;
	early_next.mask_sign  = 1'b0;
	early_next.mask_equal = 1'b0;

	case (rec.decoded.op)
		OP_BEQ: early_next.mask_equal = 1'b1;
		OP_BNE: begin
			early_next.mask_equal = 1'b1;
			early_next.negate     = 1'b1;
		end
		OP_BLTZ, OP_BLTZAL: early_next.mask_sign = 1'b1;
		OP_BGEZ, OP_BGEZAL: begin
			early_next.mask_sign = 1'b1;
			early_next.negate    = 1'b1;
		end
		OP_BLEZ: begin
			early_next.mask_sign  = 1'b1;
			early_next.mask_equal = 1'b1;
		end
		OP_BGTZ: begin
			early_next.mask_sign  = 1'b1;
			early_next.mask_equal = 1'b1;
			early_next.negate     = 1'b1;
		end
		default: ;
	endcase

	case (rec.decoded.op)
		OP_JAL:  early_next.target = {pc_plus4[31:28], rec.instr[`INSTR_INDEX], 2'b00};
		OP_JALR: early_next.target = rec.delayed_reg[0];
		default: early_next.target = pc_plus4 + br_offset;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		ent_valid <= 1'b0;
		res_cnt   <= CNT_W'(RESULT_DEPTH);
	end else begin
		if (rec_valid)
			ent_valid <= 1'b1;
		else if (send)
			ent_valid <= 1'b0;
		res_cnt <= res_cnt - CNT_W'(send) + CNT_W'(down.credit);
	end
end

always_ff @(posedge clk) begin
	if (rec_valid) begin
		ent       <= rec;
		ent_early <= early_next;
	end
end

// decode only sends after our slot was freed
assert property (@(posedge clk) disable iff (!rst_n) rec_valid |-> !ent_valid)
	else $error("record arrived while the early slot was occupied");

endmodule

// File: design/decode_stage.sv
`include "cpu_defs.svh"

module decode_stage #(
	parameter int IN_DEPTH = 2
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  cpu_types_pkg::addr_t          in_pc,
	input  cpu_types_pkg::instr_t         in_instr,
	input  cpu_types_pkg::uint32_t [1:0]  in_reg,
	input  branch_pkg::branch_predict_t   in_predict,
	output logic                          in_credit,
	output logic                          rec_valid,
	output cpu_types_pkg::pipeline_exec_t rec,
	input  logic                          rec_credit
);

import cpu_types_pkg::*;
import branch_pkg::*;

localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
localparam int CNT_W = $clog2(IN_DEPTH + 1);

typedef struct packed {
	addr_t           pc;
	instr_t          instr;
	uint32_t [1:0]   regs;
	branch_predict_t predict;
} in_entry_t;

in_entry_t        buf_mem [IN_DEPTH];
logic [PTR_W-1:0] wr_ptr, rd_ptr;
logic [CNT_W-1:0] count;
logic [1:0]       rec_cnt;
logic             pop;
in_entry_t        head;
decoded_t         dec;
pipeline_exec_t   rec_next;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign pop       = (count != '0) && (rec_cnt != 2'd0);
assign in_credit = pop;
assign head      = buf_mem[rd_ptr];

always_ff @(posedge clk) begin
	if (in_valid)
		buf_mem[wr_ptr] <= '{pc: in_pc, instr: in_instr, regs: in_reg, predict: in_predict};
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr    <= '0;
		rd_ptr    <= '0;
		count     <= '0;
		rec_cnt   <= 2'd1;
		rec_valid <= 1'b0;
	end else begin
		if (in_valid)
			wr_ptr <= ptr_inc(wr_ptr);
		if (pop)
			rd_ptr <= ptr_inc(rd_ptr);
		count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
		rec_cnt   <= rec_cnt + {1'b0, rec_credit} - {1'b0, pop};
		rec_valid <= pop;
	end
end

always_ff @(posedge clk) begin
	if (pop)
		rec <= rec_next;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	case (head.instr[`INSTR_OPCODE])
		6'h00: begin
			case (head.instr[`INSTR_FUNCT])
				6'h00:   dec.op = OP_SLL;
				6'h02:   dec.op = OP_SRL;
				6'h03:   dec.op = OP_SRA;
				6'h04:   dec.op = OP_SLLV;
				6'h06:   dec.op = OP_SRLV;
				6'h07:   dec.op = OP_SRAV;
				6'h09:   dec.op = OP_JALR;
				6'h21:   dec.op = OP_ADDU;
				6'h23:   dec.op = OP_SUBU;
				6'h24:   dec.op = OP_AND;
				6'h25:   dec.op = OP_OR;
				6'h26:   dec.op = OP_XOR;
				6'h27:   dec.op = OP_NOR;
				6'h2a:   dec.op = OP_SLT;
				6'h2b:   dec.op = OP_SLTU;
				default: dec.op = OP_INVALID;
			endcase
		end
		// regimm selected by rt
		6'h01: begin
			case (head.instr[`INSTR_RT])
				5'h00:   dec.op = OP_BLTZ;
				5'h01:   dec.op = OP_BGEZ;
				5'h10:   dec.op = OP_BLTZAL;
				5'h11:   dec.op = OP_BGEZAL;
				default: dec.op = OP_INVALID;
			endcase
		end
		6'h03:   dec.op = OP_JAL;
		6'h04:   dec.op = OP_BEQ;
		6'h05:   dec.op = OP_BNE;
		6'h06:   dec.op = OP_BLEZ;
		6'h07:   dec.op = OP_BGTZ;
		default: dec.op = OP_INVALID;
	endcase

	case (dec.op)
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ: dec.cf = CF_BRANCH;
		OP_BLTZAL, OP_BGEZAL, OP_JAL:                       dec.cf = CF_CALL;
		OP_JALR:                                            dec.cf = CF_JUMP_REG;
		default:                                            dec.cf = CF_NONE;
	endcase

	dec.is_controlflow = (dec.cf != CF_NONE);
	dec.delayed_exec   = (dec.op != OP_INVALID);
	dec.is_link        = (dec.cf == CF_CALL) || (dec.op == OP_JALR);
end

always_comb begin
	rec_next.valid          = 1'b1;
	rec_next.pc             = head.pc;
	rec_next.instr          = head.instr;
	rec_next.decoded        = dec;
	rec_next.delayed_reg    = head.regs;
	rec_next.result         = '0;
	rec_next.branch_predict = head.predict;

	// compare against zero
	case (dec.op)
		OP_BLTZ, OP_BGEZ, OP_BLEZ, OP_BGTZ, OP_BLTZAL, OP_BGEZAL:
			rec_next.delayed_reg[1] = '0;
		default: ;
	endcase

	if (dec.is_link)
		rec_next.result = head.pc + 32'd8;
end

// early stage has a single slot
assert property (@(posedge clk) disable iff (!rst_n) rec_cnt <= 2'd1)
	else $error("decode holds more credits than the early stage has slots");

endmodule

// File: design/exec_stream_if.sv
interface exec_stream_if;

import cpu_types_pkg::*;
import branch_pkg::*;

logic                   valid;
pipeline_exec_t         data;
branch_early_resolved_t early;
// one pulse per entry leaving the result FIFO
logic                   credit;

modport src (
	output valid,
	output data,
	output early,
	input  credit
);

modport dst (
	input  valid,
	input  data,
	input  early,
	output credit
);

endinterface

// File: design/cpu_types_pkg.sv
package cpu_types_pkg;

import branch_pkg::*;

typedef logic [31:0] uint32_t;
typedef vaddr_t      addr_t;
typedef logic [31:0] instr_t;
typedef logic [4:0]  shamt_t;

typedef enum logic [4:0] {
	OP_AND, OP_OR, OP_XOR, OP_NOR,
	OP_ADDU, OP_SUBU,
	OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
	OP_SLT, OP_SLTU,
	OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
	OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
	OP_JAL, OP_JALR,
	OP_INVALID
} oper_t;

// same encoding as the cf field of the resolved branch
typedef enum logic [$bits(cf_code_t)-1:0] {
	CF_NONE,
	CF_BRANCH,
	CF_CALL,
	CF_JUMP_REG
} cf_t;

typedef struct packed {
	oper_t op;
	cf_t   cf;
	logic  is_controlflow;
	logic  delayed_exec;
	logic  is_link;
} decoded_t;

typedef struct packed {
	logic            valid;
	addr_t           pc;
	instr_t          instr;
	decoded_t        decoded;
	uint32_t [1:0]   delayed_reg;
	uint32_t         result;
	branch_predict_t branch_predict;
} pipeline_exec_t;

endpackage

// File: design/branch_pkg.sv
package branch_pkg;

typedef logic [31:0] vaddr_t;
typedef logic [1:0]  counter_t;
typedef logic [1:0]  cf_code_t;

// static prediction that travels with the instruction
typedef struct packed {
	logic     valid;
	logic     taken;
	vaddr_t   target;
	counter_t counter;
} branch_predict_t;

// condition flags and masks resolved a stage early
typedef struct packed {
	vaddr_t target;
	logic   negate;
	logic   cond_sign;
	logic   cond_equal;
	logic   mask_sign;
	logic   mask_equal;
} branch_early_resolved_t;

typedef struct packed {
	logic     valid;
	vaddr_t   pc;
	cf_code_t cf;
	counter_t counter;
	logic     taken;
	vaddr_t   target;
	logic     mispredict;
} branch_resolved_t;

endpackage

// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// instruction field positions
`define INSTR_OPCODE 31:26
`define INSTR_RS     25:21
`define INSTR_RT     20:16
`define INSTR_SHAMT  10:6
`define INSTR_FUNCT  5:0
`define INSTR_IMM16  15:0
`define INSTR_INDEX  25:0

`endif
